// File: src/obj_pkg.sv
// Shared widths, pixel and object-table types for the sprite layer.
// Every RTL file of the sprite pipeline imports this package with a wildcard.

package obj_pkg;

    localparam int OBJ_COUNT_DEFAULT = 64;   // entries in the object table

    localparam int CODE_W = 12;  // tile code
    localparam int PAL_W  = 5;   // palette select
    localparam int COL_W  = 4;   // colour index inside a palette
    localparam int ROW_W  = 4;   // tile row, 16 rows per tile

    localparam int ROM_AW = CODE_W + ROW_W;   // code and row
    localparam int ROM_DW = 32;               // eight 4-bit pixels

    // colour 15 in the graphics ROM is see-through
    localparam logic [COL_W-1:0] TRANSP_COL = '1;

    typedef logic [8:0] hpos_t;   // also the line buffer address
    typedef logic [8:0] vpos_t;

    typedef struct packed {
        logic [PAL_W-1:0] pal;
        logic [COL_W-1:0] col;
    } pxl_t;

    // all ones marks an empty buffer location
    localparam pxl_t BLANK_PXL = '1;

    typedef struct packed {
        hpos_t             x;
        vpos_t             y;
        logic [CODE_W-1:0] code;
        logic [PAL_W-1:0]  pal;
    } obj_entry_t;

endpackage

// File: src/obj_draw_if.sv
// One drawing job, passed from the table scanner to the tile drawer.
// start is a single-cycle strobe, valid only while idle is high. The job
// fields stay put from start until idle comes back.

interface obj_draw_if import obj_pkg::*; ();

    logic              start;
    logic              idle;     // drawer is free
    logic [CODE_W-1:0] code;
    logic [ROW_W-1:0]  row;      // tile row for this line
    logic [PAL_W-1:0]  palette;
    hpos_t             hpos;     // leftmost screen column

    modport producer (
        output start, code, row, palette, hpos,
        input  idle
    );

    modport consumer (
        input  start, code, row, palette, hpos,
        output idle
    );

endinterface

// File: src/obj_table.sv
// Object attribute table. The CPU writes whole entries one at a time,
// and the line scanner reads them back with one cycle of latency.
// Contents are not cleared by reset, so unused entries need an off-screen y.

module obj_table import obj_pkg::*; #(
    parameter int OBJ_COUNT = OBJ_COUNT_DEFAULT
) (
    input                                clk,

    // CPU side
    input                                obj_we,
    input        [$clog2(OBJ_COUNT)-1:0] obj_index,
    input  obj_entry_t                   obj_din,

    // scanner side
    input        [$clog2(OBJ_COUNT)-1:0] scan_addr,
    output obj_entry_t                   entry
);

    obj_entry_t mem [OBJ_COUNT];

    always_ff @(posedge clk) begin
        if (obj_we) begin
            mem[obj_index] <= obj_din;
        end
        entry <= mem[scan_addr];   // old data on a same-cycle write
    end

endmodule

// File: src/obj_scan.sv
// Line scanner. After each line_start it walks the whole object table,
// two cycles per entry, and hands every object crossing vrender to the
// drawer. Table order is drawing order, so higher indices end up on top.

module obj_scan import obj_pkg::*; #(
    parameter int OBJ_COUNT = OBJ_COUNT_DEFAULT
) (
    input                                clk,
    input                                reset,
    input                                line_start,
    input  vpos_t                        vrender,   // line being built

    // table read port
    output       [$clog2(OBJ_COUNT)-1:0] scan_addr,
    input  obj_entry_t                   entry,

    obj_draw_if.producer                 dr
);

    localparam int AW = $clog2(OBJ_COUNT);

    typedef enum logic [1:0] {
        S_DONE,
        S_FETCH,   // address out, entry arrives next cycle
        S_TEST
    } state_t;

    state_t        state;
    logic [AW-1:0] idx;
    vpos_t         vline;
    vpos_t         dy;
    logic          visible;
    logic          launch;

    assign scan_addr = idx;

    // wraps modulo 512, so objects near y=511 reach the top rows
    assign dy      = vline - entry.y;
    assign visible = dy[8:ROW_W] == '0;
    assign launch  = state == S_TEST && visible && dr.idle;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_DONE;
            idx      <= '0;
            dr.start <= 1'b0;
        end else begin
            dr.start <= 1'b0;
            if (line_start) begin   // also cuts short an unfinished walk
                idx   <= '0;
                state <= S_FETCH;
            end else begin
                case (state)
                    S_FETCH: state <= S_TEST;
                    S_TEST: begin
                        if (!visible || dr.idle) begin   // otherwise hold the entry
                            dr.start <= visible;
                            if (idx == AW'(OBJ_COUNT - 1)) begin
                                state <= S_DONE;
                            end else begin
                                idx   <= idx + 1'b1;
                                state <= S_FETCH;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // job fields, held until the next launch
    always_ff @(posedge clk) begin
        if (line_start) begin
            vline <= vrender;
        end
        if (launch) begin
            dr.code    <= entry.code;
            dr.row     <= dy[ROW_W-1:0];
            dr.palette <= entry.pal;
            dr.hpos    <= entry.x;
        end
    end

endmodule

// File: src/obj_draw.sv
// Tile drawer. For each job it reads the two 8-pixel halves of one tile
// row from the graphics ROM, using the rom_cs/rom_ok level handshake,
// then writes the opaque pixels of each half into the line buffer,
// one per cycle. rom_cs is low while the pixels of a half go out.

module obj_draw import obj_pkg::*; (
    input                     clk,
    input                     reset,

    obj_draw_if.consumer      dr,

    // graphics ROM
    output       [ROM_AW-1:0] rom_addr,
    output                    rom_half,
    output logic              rom_cs,
    input        [ROM_DW-1:0] rom_data,
    input                     rom_ok,

    // line buffer
    output logic              buf_wr,
    output hpos_t             buf_addr,
    output pxl_t              buf_data
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,   // rom_cs high, waiting for rom_ok
        S_PIXEL
    } state_t;

    state_t            state;
    logic              half;
    logic [2:0]        cnt;     // nibble within the half
    logic [ROM_DW-1:0] pix;     // current nibble sits at the bottom

    // code and row are held by the scanner for the whole job
    assign rom_addr = {dr.code, dr.row};
    assign rom_half = half;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= S_IDLE;
            dr.idle <= 1'b1;
            rom_cs  <= 1'b0;
            buf_wr  <= 1'b0;
            half    <= 1'b0;
            cnt     <= '0;
        end else begin
            buf_wr <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (dr.start) begin
                        dr.idle <= 1'b0;
                        half    <= 1'b0;
                        rom_cs  <= 1'b1;
                        state   <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        cnt    <= '0;
                        state  <= S_PIXEL;
                    end
                end
                S_PIXEL: begin
                    buf_wr <= pix[COL_W-1:0] != TRANSP_COL;
                    cnt    <= cnt + 1'b1;
                    if (cnt == 3'd7) begin
                        if (!half) begin   // second half, new request
                            half   <= 1'b1;
                            rom_cs <= 1'b1;
                            state  <= S_FETCH;
                        end else begin
                            dr.idle <= 1'b1;
                            state   <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_FETCH && rom_ok) begin
            pix <= rom_data;
        end else if (state == S_PIXEL) begin
            pix <= pix >> COL_W;   // lowest nibble is leftmost
        end
        buf_addr <= dr.hpos + hpos_t'({half, cnt});   // wraps past 511
        buf_data <= '{pal: dr.palette, col: pix[COL_W-1:0]};
    end

endmodule

// File: src/obj_line.sv
// Double line buffer. The drawer fills the back bank while the display
// reads the front bank at pxl_cen and blanks each location behind it.
// Banks swap at line_start. After reset both banks are blanked, one
// address per cycle, before the display side reads anything.

module obj_line import obj_pkg::*; (
    input         clk,
    input         reset,
    input         line_start,
    input         pxl_cen,
    input  hpos_t hdump,

    // drawer side
    input         buf_wr,
    input  hpos_t buf_addr,
    input  pxl_t  buf_data,

    output pxl_t  pxl
);

    pxl_t  mem [2][512];
    logic  bank;       // front bank, on screen
    logic  clearing;
    hpos_t clr_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            bank     <= 1'b0;
            clearing <= 1'b1;
            clr_addr <= '0;
            pxl      <= BLANK_PXL;
        end else begin
            if (line_start) begin
                bank <= ~bank;
            end
            if (clearing) begin
                clr_addr <= clr_addr + 1'b1;
                if (clr_addr == 9'd511) begin
                    clearing <= 1'b0;
                end
            end else if (pxl_cen) begin
                pxl <= mem[bank][hdump];
            end
        end
    end

    // each bank sees one writer per cycle
    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[0][clr_addr] <= BLANK_PXL;
            mem[1][clr_addr] <= BLANK_PXL;
        end else begin
            if (buf_wr) begin
                mem[~bank][buf_addr] <= buf_data;
            end
            if (pxl_cen) begin
                mem[bank][hdump] <= BLANK_PXL;   // erase after read
            end
        end
    end

endmodule

// File: src/obj_engine.sv
// Sprite layer top level: object table, line scanner, tile drawer and
// line buffer in a pipeline. The CPU loads the table through the obj_*
// ports. Pixels come out on pxl, one cycle after each pxl_cen.

module obj_engine import obj_pkg::*; #(
    parameter int OBJ_COUNT = OBJ_COUNT_DEFAULT
) (
    input                                clk,
    input                                reset,
    input                                pxl_cen,
    input                                line_start,
    input  vpos_t                        vrender,   // one line ahead of the display
    input  hpos_t                        hdump,

    // table writes
    input                                obj_we,
    input        [$clog2(OBJ_COUNT)-1:0] obj_index,
    input  hpos_t                        obj_din_x,
    input  vpos_t                        obj_din_y,
    input        [CODE_W-1:0]            obj_din_code,
    input        [PAL_W-1:0]             obj_din_pal,

    // graphics ROM
    output       [ROM_AW-1:0]            rom_addr,
    output                               rom_half,
    output                               rom_cs,
    input        [ROM_DW-1:0]            rom_data,
    input                                rom_ok,

    output pxl_t                         pxl
);

    obj_entry_t                   obj_din;
    obj_entry_t                   entry;
    logic [$clog2(OBJ_COUNT)-1:0] scan_addr;
    logic                         buf_wr;
    hpos_t                        buf_addr;
    pxl_t                         buf_data;

    obj_draw_if dr_if();

    assign obj_din = '{x: obj_din_x, y: obj_din_y, code: obj_din_code, pal: obj_din_pal};

    obj_table #(.OBJ_COUNT(OBJ_COUNT)) u_table(
        .clk        ( clk           ),
        .obj_we     ( obj_we        ),
        .obj_index  ( obj_index     ),
        .obj_din    ( obj_din       ),
        .scan_addr  ( scan_addr     ),
        .entry      ( entry         )
    );

    obj_scan #(.OBJ_COUNT(OBJ_COUNT)) u_scan(
        .clk        ( clk           ),
        .reset      ( reset         ),
        .line_start ( line_start    ),
        .vrender    ( vrender       ),
        .scan_addr  ( scan_addr     ),
        .entry      ( entry         ),
        .dr         ( dr_if         )
    );

    obj_draw u_draw(
        .clk        ( clk           ),
        .reset      ( reset         ),
        .dr         ( dr_if         ),
        .rom_addr   ( rom_addr      ),
        .rom_half   ( rom_half      ),
        .rom_cs     ( rom_cs        ),
        .rom_data   ( rom_data      ),
        .rom_ok     ( rom_ok        ),
        .buf_wr     ( buf_wr        ),
        .buf_addr   ( buf_addr      ),
        .buf_data   ( buf_data      )
    );

    obj_line u_line(
        .clk        ( clk           ),
        .reset      ( reset         ),
        .line_start ( line_start    ),
        .pxl_cen    ( pxl_cen       ),
        .hdump      ( hdump         ),
        .buf_wr     ( buf_wr        ),
        .buf_addr   ( buf_addr      ),
        .buf_data   ( buf_data      ),
        .pxl        ( pxl           )
    );

endmodule

// File: bench/obj_engine_properties.sv
// Concurrent checks on the tile drawer, bound into every obj_draw instance.
// Covers the ROM request hold, the start/idle rule and transparent pixels.

module obj_engine_properties import obj_pkg::*; (
    input              clk,
    input              reset,
    input              rom_cs,
    input              rom_ok,
    input [ROM_AW-1:0] rom_addr,
    input              rom_half,
    input              start,
    input              idle,
    input              buf_wr,
    input pxl_t        buf_data
);

    // request frozen until the ROM answers
    rom_hold: assert property (@(posedge clk) disable iff (reset)
        rom_cs && !rom_ok |=> $stable(rom_addr) && $stable(rom_half))
        else $error("ROM request changed before rom_ok");

    start_when_idle: assert property (@(posedge clk) disable iff (reset)
        start |-> idle)
        else $error("start arrived while the drawer was busy");

    no_transp_write: assert property (@(posedge clk) disable iff (reset)
        buf_wr |-> buf_data.col != TRANSP_COL)
        else $error("colour 15 written into the line buffer");

endmodule

bind obj_draw obj_engine_properties u_props (
    .clk(clk), .reset(reset), .rom_cs(rom_cs), .rom_ok(rom_ok),
    .rom_addr(rom_addr), .rom_half(rom_half), .start(dr.start), .idle(dr.idle),
    .buf_wr(buf_wr), .buf_data(buf_data)
);

// File: bench/obj_engine_tb.sv
// Testbench for the sprite layer. Loads object tables, runs video lines with
// a pixel enable on every other cycle, answers ROM requests with random delay
// and compares every displayed pixel with a line built from the table copy.

module obj_engine_tb import obj_pkg::*; ();

    localparam int OBJ_COUNT    = OBJ_COUNT_DEFAULT;
    localparam int AW           = $clog2(OBJ_COUNT);
    localparam int LINE_CYCLES  = 1024;
    localparam int CLEAR_CYCLES = 512;   // line buffer blanking after reset
    localparam int NUM_LINES    = 30;    // all tests plus the final flush line
    localparam int SETUP_CYCLES = 1200;  // reset, clearing and table loads
    localparam int CYCLE_LIMIT  = NUM_LINES * LINE_CYCLES + 2 * SETUP_CYCLES;

    logic              clk          = 1'b0;
    logic              reset        = 1'b1;
    logic              pxl_cen      = 1'b0;
    logic              line_start   = 1'b0;
    vpos_t             vrender      = '0;
    hpos_t             hdump        = '0;
    logic              obj_we       = 1'b0;
    logic [AW-1:0]     obj_index    = '0;
    hpos_t             obj_din_x    = '0;
    vpos_t             obj_din_y    = '0;
    logic [CODE_W-1:0] obj_din_code = '0;
    logic [PAL_W-1:0]  obj_din_pal  = '0;
    logic [ROM_AW-1:0] rom_addr;
    logic              rom_half;
    logic              rom_cs;
    logic [ROM_DW-1:0] rom_data     = '0;
    logic              rom_ok       = 1'b0;
    pxl_t              pxl;

    integer seed     = 63932;
    int     rom_wait = 0;
    int     errors   = 0;
    int     checks   = 0;
    int     cycles   = 0;

    // table copy and expected lines
    hpos_t             tab_x    [OBJ_COUNT];
    vpos_t             tab_y    [OBJ_COUNT];
    logic [CODE_W-1:0] tab_code [OBJ_COUNT];
    logic [PAL_W-1:0]  tab_pal  [OBJ_COUNT];
    pxl_t              disp_exp [512];   // line now on screen
    pxl_t              next_exp [512];   // line being drawn

    logic  chk_pending = 1'b0;
    pxl_t  chk_exp     = BLANK_PXL;
    hpos_t chk_hdump   = '0;

    obj_engine #(.OBJ_COUNT(OBJ_COUNT)) UUT (
        .clk(clk), .reset(reset), .pxl_cen(pxl_cen), .line_start(line_start),
        .vrender(vrender), .hdump(hdump),
        .obj_we(obj_we), .obj_index(obj_index), .obj_din_x(obj_din_x),
        .obj_din_y(obj_din_y), .obj_din_code(obj_din_code), .obj_din_pal(obj_din_pal),
        .rom_addr(rom_addr), .rom_half(rom_half), .rom_cs(rom_cs),
        .rom_data(rom_data), .rom_ok(rom_ok), .pxl(pxl)
    );

    initial begin : clock_gen
        forever #10 clk = ~clk;
    end

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // pixel n of a half is base + 3n so about one half in two holds a 15
    function automatic logic [31:0] rom_word(input logic [ROM_AW-1:0] addr, input logic half);
        logic [31:0] w;
        logic [3:0]  base;
        base = addr[3:0] ^ addr[7:4] ^ addr[11:8] ^ addr[15:12];
        base = base + (half ? 4'd5 : 4'd0);
        for (int n = 0; n < 8; n++) begin
            w[4*n +: 4] = base + 4'(3 * n);
        end
        return w;
    endfunction

    // later table entries overwrite earlier ones
    function automatic pxl_t expected_pixel(input vpos_t v, input hpos_t x);
        pxl_t        p;
        vpos_t       dy;
        hpos_t       sx;
        logic [31:0] w;
        logic [3:0]  c;
        p = BLANK_PXL;
        for (int i = 0; i < OBJ_COUNT; i++) begin
            dy = v - tab_y[i];   // modulo 512
            if (dy < 9'd16) begin
                for (int h = 0; h < 2; h++) begin
                    w = rom_word({tab_code[i], dy[3:0]}, h[0]);
                    for (int n = 0; n < 8; n++) begin
                        sx = tab_x[i] + hpos_t'(8 * h + n);
                        c  = w[4*n +: 4];
                        if (sx == x && c != 4'hf) begin
                            p = '{pal: tab_pal[i], col: c};
                        end
                    end
                end
            end
        end
        return p;
    endfunction

    initial begin : rom_model
        forever begin
            @(posedge clk);
            if (rom_cs && !rom_ok) begin
                if (rom_wait == 0) begin
                    rom_data <= rom_word(rom_addr, rom_half);
                    rom_ok   <= 1'b1;
                end else begin
                    rom_wait = rom_wait - 1;
                end
            end else begin
                rom_ok   <= 1'b0;
                rom_wait = rnd(6);   // 1 to 6 cycles of latency
            end
        end
    end

    task automatic pause(input int n);
        repeat (n) begin
            @(posedge clk);
            obj_we     <= 1'b0;
            pxl_cen    <= 1'b0;
            line_start <= 1'b0;
        end
    endtask

    task automatic write_entry(input int idx, input hpos_t x, input vpos_t y,
                               input logic [CODE_W-1:0] code, input logic [PAL_W-1:0] pal);
        @(posedge clk);
        obj_we       <= 1'b1;
        obj_index    <= AW'(idx);
        obj_din_x    <= x;
        obj_din_y    <= y;
        obj_din_code <= code;
        obj_din_pal  <= pal;
        tab_x[idx]    = x;
        tab_y[idx]    = y;
        tab_code[idx] = code;
        tab_pal[idx]  = pal;
    endtask

    // y from 300 up stays off every line used here
    task automatic hide_all();
        for (int i = 0; i < OBJ_COUNT; i++) begin
            write_entry(i, hpos_t'(rnd(512)), vpos_t'(300 + rnd(160)),
                        CODE_W'(rnd(4096)), PAL_W'(rnd(32)));
        end
    endtask

    // four objects near first_line in random slots so at most four are visible
    task automatic load_random_table(output vpos_t first_line);
        first_line = vpos_t'(16 + rnd(235));
        hide_all();
        for (int k = 0; k < 4; k++) begin
            write_entry(rnd(OBJ_COUNT), hpos_t'(rnd(512)), first_line + 9'd3 - vpos_t'(rnd(16)),
                        CODE_W'(rnd(4096)), PAL_W'(rnd(32)));
        end
    endtask

    task automatic run_line(input vpos_t v);
        for (int c = 0; c < LINE_CYCLES; c++) begin
            @(posedge clk);
            if (c == 0) begin   // banks swap here
                disp_exp = next_exp;
                for (int x = 0; x < 512; x++) begin
                    next_exp[x] = expected_pixel(v, hpos_t'(x));
                end
            end
            line_start <= (c == 0);
            vrender    <= v;
            pxl_cen    <= c[0];
            hdump      <= hpos_t'(c >> 1);
        end
    endtask

    // pxl is due one cycle after the pxl_cen cycle
    always @(negedge clk) begin : compare_pixels
        if (chk_pending) begin
            checks++;
            assert (pxl == chk_exp) else begin
                errors++;
                $display("[FAIL] %0t: pxl at hdump %0d is %h, expected %h",
                         $time, chk_hdump, pxl, chk_exp);
            end
        end
        chk_pending = pxl_cen;
        chk_exp     = disp_exp[hdump];
        chk_hdump   = hdump;
    end

    initial begin : watchdog
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the test sequence did not complete", cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : stimulus
        vpos_t first;
        for (int x = 0; x < 512; x++) begin
            disp_exp[x] = BLANK_PXL;
            next_exp[x] = BLANK_PXL;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        pause(CLEAR_CYCLES + 8);

        hide_all();   // empty table
        pause(2);
        run_line(9'd20);
        run_line(9'd21);

        pause(1);   // one object
        hide_all();
        write_entry(5, 9'd100, 9'd40, 12'h123, 5'd9);
        pause(2);
        run_line(9'd45);
        run_line(9'd46);

        pause(1);   // overlap with entry 20 on top
        hide_all();
        write_entry(3, 9'd200, 9'd60, 12'h0a5, 5'd3);
        write_entry(10, 9'd208, 9'd58, 12'h3c1, 5'd17);
        write_entry(20, 9'd204, 9'd62, 12'h7e2, 5'd30);
        pause(2);
        run_line(9'd62);
        run_line(9'd63);

        pause(1);   // wrap in x and in y
        hide_all();
        write_entry(1, 9'd506, 9'd505, 12'h451, 5'd12);
        write_entry(2, 9'd504, 9'd510, 12'h9b8, 5'd21);
        pause(2);
        run_line(9'd0);
        run_line(9'd1);
        run_line(9'd2);

        for (int t = 0; t < 5; t++) begin
            pause(1);
            load_random_table(first);
            pause(2);
            for (int j = 0; j < 4; j++) begin
                run_line(first + vpos_t'(j));
            end
        end
        run_line(9'd280);   // shows the last drawn line
        pause(3);

        $display("%0d pixel checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: obj_engine.f
src/obj_pkg.sv
src/obj_draw_if.sv
src/obj_table.sv
src/obj_scan.sv
src/obj_draw.sv
src/obj_line.sv
src/obj_engine.sv
bench/obj_engine_properties.sv
bench/obj_engine_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the sprite layer testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
EXE=obj_engine_sim
LOG=sim.log

if ! verilator --binary --timing --assert -j 0 \
        --top-module obj_engine_tb -f obj_engine.f \
        --Mdir "$BUILD_DIR" -o "$EXE"; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
